// File: flist.f
+incdir+include
src/rv32_types_pkg.sv
src/bpred_pkg.sv
src/btb_dispatch.sv
src/btb_bank.sv
src/btb_collect.sv
src/branch_predictor.sv
verification/branch_predictor_tb.sv

// File: include/bpred_settings.svh
// Branch target buffer geometry

`ifndef BPRED_SETTINGS_SVH
`define BPRED_SETTINGS_SVH

// Number of direct-mapped banks
`define BP_NBANKS 4

// Entries in each bank
`define BP_SETS_PER_BANK 8

// Tag bits kept per entry
`define BP_TAG_BITS 8

// Index widths follow from the counts above
`define BP_BANK_BITS $clog2(`BP_NBANKS)
`define BP_SET_BITS $clog2(`BP_SETS_PER_BANK)

`endif

// File: run_sim.sh
#!/bin/sh
# Build and run the branch predictor testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f \
    --top-module branch_predictor_tb -Mdir obj_dir -o branch_predictor_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/branch_predictor_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Verification passed"; then
    exit 0
fi
exit 1

// File: src/bpred_pkg.sv
// Branch predictor types

`include "bpred_settings.svh"

package bpred_pkg;

    import rv32_types_pkg::*;

    // Index and tag vectors
    typedef logic [`BP_BANK_BITS-1:0] bank_idx_t;
    typedef logic [`BP_SET_BITS-1:0]  set_idx_t;
    typedef logic [`BP_TAG_BITS-1:0]  tag_t;

    // 2-bit hysteresis counter, MSB set means predict taken
    typedef enum logic [1:0] {
        SNT = 2'b00, // strongly not taken
        WNT = 2'b01, // weakly not taken
        WT  = 2'b10, // weakly taken
        ST  = 2'b11  // strongly taken
    } ctr_t;

    // PC split into BTB fields
    typedef struct packed {
        logic [$bits(pc_t)-`BP_TAG_BITS-`BP_SET_BITS-`BP_BANK_BITS-2:0] ignore; // above the tag
        tag_t      tag;
        set_idx_t  set;
        bank_idx_t bank;
        logic      half;   // always 0, PCs are halfword aligned
    } pc_fields_t;

    // One BTB entry
    typedef struct packed {
        logic valid;
        tag_t tag;
        pc_t  target;
        ctr_t ctr;
    } btb_entry_t;

    // Lookup from fetch
    typedef struct packed {
        pc_t  pc;
        logic is_branch;
        logic is_rvc;      // compressed, falls through by 2
    } lookup_req_t;

    // Lookup as seen by a bank
    typedef struct packed {
        set_idx_t set;
        tag_t     tag;
        pc_t      pc;
        logic     is_branch;
        logic     is_rvc;
    } bank_req_t;

    // Resolved branch from execute
    typedef struct packed {
        logic valid;       // write on this edge
        pc_t  pc;
        pc_t  target;
        logic taken;
    } bp_update_t;

    // Bank stage register contents
    typedef struct packed {
        logic hit;
        pc_t  target;
        ctr_t ctr;
        pc_t  pc;
        logic is_branch;
        logic is_rvc;
    } bank_resp_t;

    // Final prediction back to fetch
    typedef struct packed {
        pc_t  pc;
        logic taken;
        pc_t  next_pc;
    } prediction_t;

endpackage

// File: src/branch_predictor.sv
// Banked branch target buffer

`timescale 1ns/10ps

`include "bpred_settings.svh"

module branch_predictor
    import bpred_pkg::*;
(
    input  logic        CLK,
    input  logic        nRST,
    input  logic        req_valid,
    output logic        req_ready,
    input  lookup_req_t req,
    output logic        resp_valid,
    input  logic        resp_ready,
    output prediction_t pred,
    input  bp_update_t  update
);

    logic                  advance;
    logic                  accept;      // lookup handshake
    bank_req_t             bank_req;
    logic [`BP_NBANKS-1:0] bank_sel;
    logic [`BP_NBANKS-1:0] upd_sel;
    logic [`BP_NBANKS-1:0] stage_valid;
    bank_resp_t            bank_resp [`BP_NBANKS];

    assign req_ready = advance;
    assign accept    = req_valid && advance;

    btb_dispatch btb_dispatch_i (
        .CLK      (CLK),
        .nRST     (nRST),
        .req      (req),
        .accept   (accept),
        .update   (update),
        .bank_req (bank_req),
        .bank_sel (bank_sel),
        .upd_sel  (upd_sel)
    );

    // One bank per PC bank index
    for (genvar b = 0; b < `BP_NBANKS; b++) begin : g_bank
        btb_bank btb_bank_i (
            .CLK         (CLK),
            .nRST        (nRST),
            .lookup_en   (bank_sel[b]),
            .req         (bank_req),
            .advance     (advance),
            .upd_en      (upd_sel[b]),
            .update      (update),
            .stage_valid (stage_valid[b]),
            .resp        (bank_resp[b])
        );
    end

    btb_collect btb_collect_i (
        .CLK         (CLK),
        .nRST        (nRST),
        .stage_valid (stage_valid),
        .resp        (bank_resp),
        .resp_ready  (resp_ready),
        .advance     (advance),
        .resp_valid  (resp_valid),
        .pred        (pred)
    );

endmodule

// File: src/btb_bank.sv
// Direct-mapped BTB bank

`timescale 1ns/10ps

`include "bpred_settings.svh"

module btb_bank
    import bpred_pkg::*;
(
    input  logic       CLK,
    input  logic       nRST,
    input  logic       lookup_en,   // this bank owns the lookup
    input  bank_req_t  req,
    input  logic       advance,     // downstream can move
    input  logic       upd_en,      // this bank owns the update
    input  bp_update_t update,
    output logic       stage_valid,
    output bank_resp_t resp
);

    // Entry array
    btb_entry_t [`BP_SETS_PER_BANK-1:0] entries;

    pc_fields_t up_f;
    btb_entry_t up_old;     // entry at update set
    ctr_t       up_prior;   // counter the update starts from
    ctr_t       up_ctr;
    btb_entry_t up_new;
    btb_entry_t rd_entry;   // entry at lookup set
    logic       rd_hit;

    assign up_f   = update.pc;
    assign up_old = entries[up_f.set];

    // Tag miss or empty slot counts as SNT
    assign up_prior = (up_old.valid && (up_old.tag == up_f.tag)) ? up_old.ctr : SNT;

    // Hysteresis counter
    always_comb begin
        case (up_prior)
            SNT:     up_ctr = update.taken ? WNT : SNT;
            WNT:     up_ctr = update.taken ? ST  : SNT;
            ST:      up_ctr = update.taken ? ST  : WT;
            WT:      up_ctr = update.taken ? ST  : SNT;
            default: up_ctr = SNT;
        endcase
    end

    // New entry always takes the resolved tag and target
    always_comb begin
        up_new.valid  = 1'b1;
        up_new.tag    = up_f.tag;
        up_new.target = update.target;
        up_new.ctr    = up_ctr;
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            entries <= '0; // all invalid
        end else if (upd_en) begin
            entries[up_f.set] <= up_new;
        end
    end

    // Lookup read, sees the array before a same-edge write
    assign rd_entry = entries[req.set];
    assign rd_hit   = rd_entry.valid && (rd_entry.tag == req.tag);

    // Stage valid, holds while downstream stalls
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            stage_valid <= 1'b0;
        end else if (advance) begin
            stage_valid <= lookup_en;
        end
    end

    // Stage payload
    always_ff @(posedge CLK) begin
        if (advance) begin
            resp.hit       <= rd_hit;
            resp.target    <= rd_entry.target;
            resp.ctr       <= rd_entry.ctr;
            resp.pc        <= req.pc;
            resp.is_branch <= req.is_branch;
            resp.is_rvc    <= req.is_rvc;
        end
    end

    // A stalled lookup must not be lost before collect takes it
    a_stage_hold: assert property (
        @(posedge CLK) disable iff (!nRST)
        (stage_valid && !advance) |=> stage_valid
    ) else $error("bank stage dropped a lookup during stall");

endmodule

// File: src/btb_collect.sv
// BTB result collect and output register

`timescale 1ns/10ps

`include "bpred_settings.svh"

module btb_collect
    import rv32_types_pkg::*;
    import bpred_pkg::*;
(
    input  logic                  CLK,
    input  logic                  nRST,
    input  logic [`BP_NBANKS-1:0] stage_valid,
    input  bank_resp_t            resp [`BP_NBANKS],
    input  logic                  resp_ready,
    output logic                  advance,
    output logic                  resp_valid,
    output prediction_t           pred
);

    bank_resp_t  sel;        // response from the valid bank
    logic        any_valid;
    logic        taken;
    pc_t         fall_through;
    prediction_t nxt_pred;

    // Output register free or draining
    assign advance = !resp_valid || resp_ready;

    // At most one bank holds a lookup
    always_comb begin
        sel = '0;
        for (int b = 0; b < `BP_NBANKS; b++) begin
            if (stage_valid[b]) begin
                sel = resp[b];
            end
        end
    end

    assign any_valid = |stage_valid;

    // Prediction
    assign taken        = sel.hit && sel.is_branch && sel.ctr[1]; // counter MSB
    assign fall_through = sel.pc + (sel.is_rvc ? pc_t'(2) : pc_t'(4));

    always_comb begin
        nxt_pred.pc      = sel.pc;
        nxt_pred.taken   = taken;
        nxt_pred.next_pc = taken ? sel.target : fall_through;
    end

    // Output valid
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            resp_valid <= 1'b0;
        end else if (advance) begin
            resp_valid <= any_valid;
        end
    end

    // Output payload
    always_ff @(posedge CLK) begin
        if (advance) begin
            pred <= nxt_pred;
        end
    end

    // Dispatch and banks together keep only one lookup per stage
    a_one_stage_valid: assert property (
        @(posedge CLK) disable iff (!nRST)
        $onehot0(stage_valid)
    ) else $error("more than one bank stage valid");

    // Stalled response stays put until fetch takes it
    a_pred_stable: assert property (
        @(posedge CLK) disable iff (!nRST)
        (resp_valid && !resp_ready) |=> (resp_valid && $stable(pred))
    ) else $error("prediction changed while stalled");

endmodule

// File: src/btb_dispatch.sv
// BTB request dispatch

`timescale 1ns/10ps

`include "bpred_settings.svh"

module btb_dispatch
    import bpred_pkg::*;
(
    input  logic                   CLK,
    input  logic                   nRST,
    input  lookup_req_t            req,
    input  logic                   accept,   // lookup taken this edge
    input  bp_update_t             update,
    output bank_req_t              bank_req,
    output logic [`BP_NBANKS-1:0]  bank_sel, // one-hot lookup enable
    output logic [`BP_NBANKS-1:0]  upd_sel   // one-hot write enable
);

    pc_fields_t lk_f;
    pc_fields_t up_f;

    // Overlay the field layout on both PCs
    assign lk_f = req.pc;
    assign up_f = update.pc;

    // Shared request, every bank sees the same fields
    always_comb begin
        bank_req.set       = lk_f.set;
        bank_req.tag       = lk_f.tag;
        bank_req.pc        = req.pc;
        bank_req.is_branch = req.is_branch;
        bank_req.is_rvc    = req.is_rvc;
    end

    // Bank decode
    always_comb begin
        bank_sel = '0;
        upd_sel  = '0;
        for (int b = 0; b < `BP_NBANKS; b++) begin
            // Only an accepted lookup reaches a bank
            if (accept && (lk_f.bank == bank_idx_t'(b))) begin
                bank_sel[b] = 1'b1;
            end
            if (update.valid && (up_f.bank == bank_idx_t'(b))) begin
                upd_sel[b] = 1'b1; // execute write
            end
        end
    end

    // An accepted lookup lands in exactly one bank, otherwise none is enabled
    a_bank_sel_onehot: assert property (
        @(posedge CLK) disable iff (!nRST)
        accept ? $onehot(bank_sel) : (bank_sel == '0)
    ) else $error("bank_sel not one-hot for accepted lookup");

endmodule

// File: src/rv32_types_pkg.sv
// RV32 base types

package rv32_types_pkg;

    // Native register width of RV32
    parameter int WORD_SIZE = 32;

    // Plain data word
    typedef logic [WORD_SIZE-1:0] word_t;

    // Program counter
    // Same width as a data word on RV32, kept as its own name so that
    // address paths read as addresses
    typedef word_t pc_t;

endpackage

// File: verification/branch_predictor_tb.sv
// Branch predictor testbench

`timescale 1ns/10ps

`include "bpred_settings.svh"

module branch_predictor_tb
    import rv32_types_pkg::*;
    import bpred_pkg::*;
();

    localparam int CLK_PERIOD   = 100;
    localparam int DRIVE_DLY    = 10;   // Input skew after the rising edge
    localparam int RESET_CYCLES = 16;
    // Roughly 550 cycles of reset and tests leave a wide margin
    localparam int MAX_CYCLES   = 3000;

    logic        CLK = 1'b0;
    logic        nRST;
    logic        req_valid;
    logic        req_ready;
    lookup_req_t req;
    logic        resp_valid;
    logic        resp_ready;
    prediction_t pred;
    bp_update_t  update;

    // Reference entry array with one slot per bank and set
    logic        m_valid  [`BP_NBANKS][`BP_SETS_PER_BANK];
    tag_t        m_tag    [`BP_NBANKS][`BP_SETS_PER_BANK];
    pc_t         m_target [`BP_NBANKS][`BP_SETS_PER_BANK];
    logic [1:0]  m_ctr    [`BP_NBANKS][`BP_SETS_PER_BANK];

    prediction_t exp_q [$];        // Predictions still owed by the DUT
    prediction_t last_pred;        // Last consumed response
    int          errors      = 0;  // Task-level checks
    int          checks      = 0;
    int          resp_errors = 0;  // Response monitor
    int          resp_checks = 0;
    int          cycles      = 0;
    int          seed        = 69009;

    branch_predictor branch_predictor_i (
        .CLK        (CLK),
        .nRST       (nRST),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req        (req),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .pred       (pred),
        .update     (update)
    );

    always #(CLK_PERIOD / 2) CLK = ~CLK;

    // PC layout above bit 0 is bank then set then tag
    function automatic bank_idx_t bank_of(pc_t pc);
        return bank_idx_t'(pc >> 1);
    endfunction

    function automatic set_idx_t set_of(pc_t pc);
        return set_idx_t'(pc >> (1 + `BP_BANK_BITS));
    endfunction

    function automatic tag_t tag_of(pc_t pc);
        return tag_t'(pc >> (1 + `BP_BANK_BITS + `BP_SET_BITS));
    endfunction

    // SNT=00 WNT=01 WT=10 ST=11
    function automatic logic [1:0] next_counter(logic [1:0] prior, logic taken);
        case (prior)
            2'b00:   return taken ? 2'b01 : 2'b00;
            2'b01:   return taken ? 2'b11 : 2'b00; // WNT jumps straight to ST
            2'b11:   return taken ? 2'b11 : 2'b10;
            default: return taken ? 2'b11 : 2'b00; // WT
        endcase
    endfunction

    function automatic prediction_t predict(lookup_req_t r);
        prediction_t p;
        bank_idx_t   b;
        set_idx_t    s;
        logic        hit;
        b         = bank_of(r.pc);
        s         = set_of(r.pc);
        hit       = m_valid[b][s] && (m_tag[b][s] == tag_of(r.pc));
        p.pc      = r.pc;
        p.taken   = hit && r.is_branch && m_ctr[b][s][1];
        p.next_pc = p.taken ? m_target[b][s] : r.pc + (r.is_rvc ? 32'd2 : 32'd4);
        return p;
    endfunction

    function automatic void apply_update(bp_update_t u);
        bank_idx_t  b;
        set_idx_t   s;
        logic [1:0] prior;
        b     = bank_of(u.pc);
        s     = set_of(u.pc);
        prior = (m_valid[b][s] && m_tag[b][s] == tag_of(u.pc)) ? m_ctr[b][s] : 2'b00;
        m_valid[b][s]  = 1'b1;
        m_tag[b][s]    = tag_of(u.pc);
        m_target[b][s] = u.target;
        m_ctr[b][s]    = next_counter(prior, u.taken);
    endfunction

    task automatic compare_response();
        prediction_t e;
        if (exp_q.size() == 0) begin
            resp_errors++;
            $display("Response at %0t arrived with no lookup outstanding", $time);
        end else begin
            e = exp_q.pop_front();
            resp_checks++;
            assert (pred.pc == e.pc) else begin
                resp_errors++;
                $display("[ERROR] %0t pred.pc expected %h got %h", $time, e.pc, pred.pc);
            end
            assert (pred.taken == e.taken) else begin
                resp_errors++;
                $display("[ERROR] %0t pred.taken expected %0b got %0b",
                         $time, e.taken, pred.taken);
            end
            assert (pred.next_pc == e.next_pc) else begin
                resp_errors++;
                $display("[ERROR] %0t pred.next_pc expected %h got %h",
                         $time, e.next_pc, pred.next_pc);
            end
            last_pred = pred;
        end
    endtask

    // Inputs are stable at the falling edge and show what the next rising edge does
    always @(negedge CLK) begin
        if (!nRST) begin
            exp_q.delete();
            foreach (m_valid[b, s]) m_valid[b][s] = 1'b0;
        end else begin
            if (resp_valid && resp_ready) compare_response();
            if (req_valid && req_ready) exp_q.push_back(predict(req)); // Old contents
            if (update.valid) apply_update(update);
        end
    end

    always @(posedge CLK) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, tests did not finish", cycles);
            $display("Checks: %0d, errors: %0d", checks + resp_checks, errors + resp_errors);
            $display("Verification failed");
            $finish;
        end
    end

    task automatic step_cycle();
        @(posedge CLK);
        #DRIVE_DLY;
    endtask

    // Holds req_valid until the handshake edge
    task automatic drive_lookup(pc_t pc, logic is_branch, logic is_rvc);
        req.pc        = pc;
        req.is_branch = is_branch;
        req.is_rvc    = is_rvc;
        req_valid     = 1'b1;
        @(negedge CLK);
        while (!req_ready) @(negedge CLK);
        step_cycle();
        req_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) @(posedge CLK);
        #DRIVE_DLY;
    endtask

    task automatic send_update(pc_t pc, pc_t target, logic taken);
        update.valid  = 1'b1;
        update.pc     = pc;
        update.target = target;
        update.taken  = taken;
        step_cycle(); // Written on this edge
        update.valid = 1'b0;
    endtask

    task automatic check_last(pc_t pc, logic exp_taken, pc_t exp_next);
        checks++;
        assert (last_pred.pc == pc) else begin
            errors++;
            $display("[ERROR] %0t pred.pc expected %h got %h", $time, pc, last_pred.pc);
        end
        assert (last_pred.taken == exp_taken) else begin
            errors++;
            $display("[ERROR] %0t pred.taken expected %0b got %0b",
                     $time, exp_taken, last_pred.taken);
        end
        assert (last_pred.next_pc == exp_next) else begin
            errors++;
            $display("[ERROR] %0t pred.next_pc expected %h got %h",
                     $time, exp_next, last_pred.next_pc);
        end
    endtask

    task automatic lookup_and_check(pc_t pc, logic br, logic rvc, logic tk, pc_t nxt);
        drive_lookup(pc, br, rvc);
        wait_drain();
        check_last(pc, tk, nxt);
    endtask

    task automatic cold_lookups();
        pc_t pc;
        checks++;
        assert (req_ready) else begin
            errors++;
            $display("[ERROR] %0t req_ready expected 1 got %0b", $time, req_ready);
        end
        assert (!resp_valid) else begin
            errors++;
            $display("[ERROR] %0t resp_valid expected 0 got %0b", $time, resp_valid);
        end
        for (int b = 0; b < `BP_NBANKS; b++) begin
            pc = 32'h0000_1000 | pc_t'(b << 1);
            lookup_and_check(pc, 1'b1, 1'b0, 1'b0, pc + 32'd4);
            lookup_and_check(pc + 32'h40, 1'b1, 1'b1, 1'b0, pc + 32'h42); // RVC
        end
    endtask

    task automatic counter_training();
        pc_t        pc;
        pc_t        tgt;
        logic [0:9] upd_taken;
        logic [0:9] exp_taken;
        pc        = 32'h0000_2A4C;
        tgt       = 32'h0000_8000;
        upd_taken = 10'b01_0111_0100;
        exp_taken = 10'b00_0011_1110; // SNT WNT SNT WNT ST ST WT ST WT SNT
        for (int i = 0; i < 10; i++) begin
            send_update(pc, tgt, upd_taken[i]);
            lookup_and_check(pc, 1'b1, 1'b0, exp_taken[i], exp_taken[i] ? tgt : pc + 32'd4);
        end
    endtask

    task automatic non_branch_lookups();
        pc_t pc;
        pc_t tgt;
        pc  = 32'h0000_3116;
        tgt = 32'h0000_9ABC;
        send_update(pc, tgt, 1'b1);
        send_update(pc, tgt, 1'b1); // Now ST
        lookup_and_check(pc, 1'b1, 1'b0, 1'b1, tgt);
        lookup_and_check(pc, 1'b0, 1'b0, 1'b0, pc + 32'd4);
        lookup_and_check(pc, 1'b0, 1'b1, 1'b0, pc + 32'd2);
    endtask

    task automatic tag_conflicts();
        pc_t pc_a;
        pc_t pc_b;
        pc_t pc_c;
        pc_a = 32'h0000_0152;
        pc_b = pc_a + 32'h400;   // Same bank and set with another tag
        pc_c = pc_a ^ 32'h2;     // Neighbour bank
        send_update(pc_a, 32'h0000_A000, 1'b1);
        send_update(pc_a, 32'h0000_A000, 1'b1);
        send_update(pc_c, 32'h0000_C000, 1'b1);
        send_update(pc_c, 32'h0000_C000, 1'b1);
        lookup_and_check(pc_a, 1'b1, 1'b0, 1'b1, 32'h0000_A000);
        send_update(pc_b, 32'h0000_B000, 1'b1); // Evicts A and restarts at SNT
        lookup_and_check(pc_a, 1'b1, 1'b0, 1'b0, pc_a + 32'd4);
        lookup_and_check(pc_b, 1'b1, 1'b0, 1'b0, pc_b + 32'd4);
        lookup_and_check(pc_c, 1'b1, 1'b0, 1'b1, 32'h0000_C000);
        send_update(pc_b, 32'h0000_B000, 1'b1);
        lookup_and_check(pc_b, 1'b1, 1'b0, 1'b1, 32'h0000_B000);
    endtask

    task automatic back_pressure();
        prediction_t held;
        resp_ready = 1'b0;
        drive_lookup(32'h0000_3116, 1'b1, 1'b0);   // Trained entry predicts taken
        drive_lookup(32'h0000_0500, 1'b1, 1'b1);
        req.pc        = 32'h0000_0152;
        req.is_branch = 1'b1;
        req.is_rvc    = 1'b0;
        req_valid     = 1'b1;
        held          = pred;
        repeat (5) begin
            @(negedge CLK);
            checks++;
            assert (!req_ready) else begin
                errors++;
                $display("[ERROR] %0t req_ready expected 0 got %0b", $time, req_ready);
            end
            assert (resp_valid) else begin
                errors++;
                $display("[ERROR] %0t resp_valid expected 1 got %0b", $time, resp_valid);
            end
            assert (pred == held) else begin
                errors++;
                $display("[ERROR] %0t pred expected %h got %h", $time, held, pred);
            end
        end
        step_cycle();
        resp_ready = 1'b1;
        drive_lookup(32'h0000_0152, 1'b1, 1'b0);
        wait_drain();
        check_last(32'h0000_0152, 1'b0, 32'h0000_0156);
    endtask

    task automatic random_mix();
        logic [31:0] r;
        repeat (300) begin
            r = $random(seed);
            req_valid     = r[0];
            req.is_branch = r[1];
            req.is_rvc    = r[2];
            resp_ready    = r[4] | r[5];   // Ready three cycles in four
            update.valid  = r[6];
            update.taken  = r[7];
            r = $random(seed);
            req.pc = r & 32'h0000_00FE;    // Only four tags keep hits and conflicts common
            r = $random(seed);
            update.pc = r & 32'h0000_00FE;
            r = $random(seed);
            update.target = r & ~32'h1;
            step_cycle();
        end
        req_valid    = 1'b0;
        update.valid = 1'b0;
        resp_ready   = 1'b1;
        wait_drain();
    endtask

    initial begin
        nRST       = 1'b0;
        req_valid  = 1'b0;
        req        = '0;
        resp_ready = 1'b1;
        update     = '0;
        repeat (RESET_CYCLES) @(posedge CLK);
        #DRIVE_DLY;
        nRST = 1'b1;
        cold_lookups();
        counter_training();
        non_branch_lookups();
        tag_conflicts();
        back_pressure();
        random_mix();
        repeat (4) step_cycle();
        checks++;
        assert (exp_q.size() == 0) else begin
            errors++;
            $display("Lookups still outstanding at the end of the run");
        end
        assert (!resp_valid) else begin
            errors++;
            $display("[ERROR] %0t resp_valid expected 0 got %0b", $time, resp_valid);
        end
        $display("Checks: %0d, errors: %0d", checks + resp_checks, errors + resp_errors);
        if (errors + resp_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
